//--- rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

  // base opcodes, instr[6:0]
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opAuipc  = 7'b0010111;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opJalr   = 7'b1100111;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opImm    = 7'b0010011;
  localparam logic [6:0] opReg    = 7'b0110011;

  // alu funct3
  localparam logic [2:0] f3AddSub = 3'b000;
  localparam logic [2:0] f3Sll    = 3'b001;
  localparam logic [2:0] f3Slt    = 3'b010;
  localparam logic [2:0] f3Sltu   = 3'b011;
  localparam logic [2:0] f3Xor    = 3'b100;
  localparam logic [2:0] f3SrlSra = 3'b101;
  localparam logic [2:0] f3Or     = 3'b110;
  localparam logic [2:0] f3And    = 3'b111;

  // branch funct3
  localparam logic [2:0] f3Beq  = 3'b000;
  localparam logic [2:0] f3Bne  = 3'b001;
  localparam logic [2:0] f3Blt  = 3'b100;
  localparam logic [2:0] f3Bge  = 3'b101;
  localparam logic [2:0] f3Bltu = 3'b110;
  localparam logic [2:0] f3Bgeu = 3'b111;

  // lw, sw and jalr
  localparam logic [2:0] f3Word = 3'b010;
  localparam logic [2:0] f3Jalr = 3'b000;

  // funct7, bit 5 marks sub and sra
  localparam logic [6:0] f7Base = 7'b0000000;
  localparam logic [6:0] f7Alt  = 7'b0100000;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rTypeT;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iTypeT;

  typedef struct packed {
    logic [6:0] immHi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] immLo;
    logic [6:0] opcode;
  } sTypeT;

  // branch offset scattered, bit 0 implied zero
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10to5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4to1;
    logic       imm11;
    logic [6:0] opcode;
  } bTypeT;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } uTypeT;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10to1;
    logic       imm11;
    logic [7:0] imm19to12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } jTypeT;

  // one instruction word, six views
  typedef union packed {
    rTypeT r;
    iTypeT i;
    sTypeT s;
    bTypeT b;
    uTypeT u;
    jTypeT j;
  } rvInstr;

endpackage

`default_nettype wire

//--- rvCtrlPkg.sv
`default_nettype none

package rvCtrlPkg;

  // bit 3 set means a one-bit compare result
  // then bit 2 inverts it and bits 1:0 pick eq, lt or ltu
  typedef enum logic [3:0] {
    aluAdd  = 4'b0000,
    aluSub  = 4'b0001,
    aluAnd  = 4'b0010,
    aluOr   = 4'b0011,
    aluXor  = 4'b0100,
    aluSll  = 4'b0101,
    aluSrl  = 4'b0110,
    aluSra  = 4'b0111,
    aluEq   = 4'b1000,
    aluSlt  = 4'b1001,
    aluSltu = 4'b1010,
    aluNe   = 4'b1100,
    aluGe   = 4'b1101,
    aluGeu  = 4'b1110
  } aluOpT;

  typedef enum logic [2:0] {
    immI,
    immS,
    immB,
    immU,
    immJ
  } immKindT;

  // alu operand a source
  typedef enum logic [1:0] {
    aRs1,
    aZero,
    aPc
  } aSelT;

  // register write-back source
  typedef enum logic [1:0] {
    wbAlu,
    wbMem,
    wbLink
  } wbSelT;

  typedef enum logic [1:0] {
    nextSeq,
    nextBranch,
    nextAlu
  } pcSelT;

endpackage

`default_nettype wire

//--- ctrlIf.sv
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf import rvCtrlPkg::*; ();

  aluOpT   aluOp;
  immKindT immKind;
  aSelT    aSel;
  // operand b is the immediate
  logic    bImm;
  wbSelT   wbSel;
  logic    regWrite;
  logic    memWrite;
  logic    isBranch;
  logic    isJal;
  logic    isJalr;

  modport decoder (
    output aluOp, immKind, aSel, bImm, wbSel,
    output regWrite, memWrite, isBranch, isJal, isJalr
  );

  modport datapath (
    input aluOp, immKind, aSel, bImm, wbSel,
    input regWrite, memWrite, isBranch, isJal, isJalr
  );

endinterface

`default_nettype wire

//--- instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder import rvIsaPkg::*, rvCtrlPkg::*; (
  input  rvInstr instr,
  ctrlIf.decoder ctrl
);

  logic [2:0] funct3;
  logic       alt;

  assign funct3 = instr.r.funct3;
  assign alt    = instr.r.funct7[5];

  // register and immediate alu ops share funct3
  // sub only exists in the register form
  function automatic aluOpT aluFromFunct(logic [2:0] f3, logic altBit, logic isReg);
    case (f3)
      f3AddSub: return (isReg && altBit) ? aluSub : aluAdd;
      f3Sll:    return aluSll;
      f3Slt:    return aluSlt;
      f3Sltu:   return aluSltu;
      f3Xor:    return aluXor;
      f3SrlSra: return altBit ? aluSra : aluSrl;
      f3Or:     return aluOr;
      default:  return aluAnd;
    endcase
  endfunction

  // funct3[0] inverts, funct3[2:1] pick the compare
  function automatic aluOpT branchOp(logic [2:0] f3);
    logic [1:0] cmpKind;
    if (!f3[2]) begin
      cmpKind = 2'b00;
    end else if (f3[1]) begin
      cmpKind = 2'b10;
    end else begin
      cmpKind = 2'b01;
    end
    return aluOpT'({1'b1, f3[0], cmpKind});
  endfunction

  always_comb begin
    ctrl.aluOp    = aluAdd;
    ctrl.immKind  = immI;
    ctrl.aSel     = aRs1;
    ctrl.bImm     = 1'b0;
    ctrl.wbSel    = wbAlu;
    ctrl.regWrite = 1'b0;
    ctrl.memWrite = 1'b0;
    ctrl.isBranch = 1'b0;
    ctrl.isJal    = 1'b0;
    ctrl.isJalr   = 1'b0;
    case (instr.r.opcode)
      opLui: begin
        // 0 + imm
        ctrl.immKind  = immU;
        ctrl.aSel     = aZero;
        ctrl.bImm     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      opAuipc: begin
        ctrl.immKind  = immU;
        ctrl.aSel     = aPc;
        ctrl.bImm     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      opJal: begin
        ctrl.immKind  = immJ;
        ctrl.wbSel    = wbLink;
        ctrl.regWrite = 1'b1;
        ctrl.isJal    = 1'b1;
      end
      opJalr: begin
        ctrl.bImm     = 1'b1;
        ctrl.wbSel    = wbLink;
        ctrl.regWrite = 1'b1;
        ctrl.isJalr   = 1'b1;
      end
      opBranch: begin
        ctrl.immKind  = immB;
        ctrl.aluOp    = branchOp(funct3);
        ctrl.isBranch = 1'b1;
      end
      opLoad: begin
        // word loads only
        ctrl.bImm     = 1'b1;
        ctrl.wbSel    = wbMem;
        ctrl.regWrite = (funct3 == f3Word);
      end
      opStore: begin
        ctrl.immKind  = immS;
        ctrl.bImm     = 1'b1;
        ctrl.memWrite = (funct3 == f3Word);
      end
      opImm: begin
        ctrl.bImm     = 1'b1;
        ctrl.aluOp    = aluFromFunct(funct3, alt, 1'b0);
        ctrl.regWrite = 1'b1;
      end
      opReg: begin
        ctrl.aluOp    = aluFromFunct(funct3, alt, 1'b1);
        ctrl.regWrite = 1'b1;
      end
      default: begin
        // unknown opcode, defaults write nothing
      end
    endcase
  end

endmodule

`default_nettype wire

//--- immGen.sv
`timescale 1ns/1ps
`default_nettype none

module immGen import rvIsaPkg::*, rvCtrlPkg::*; (
  input  rvInstr      instr,
  input  immKindT     immKind,
  output logic [31:0] imm
);

  always_comb begin
    case (immKind)
      immI: begin
        imm = {{20{instr.i.imm[11]}}, instr.i.imm};
      end
      immS: begin
        imm = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
      end
      immB: begin
        // bit 0 always zero
        imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
               instr.b.imm10to5, instr.b.imm4to1, 1'b0};
      end
      immU: begin
        imm = {instr.u.imm, 12'd0};
      end
      immJ: begin
        imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19to12,
               instr.j.imm11, instr.j.imm10to1, 1'b0};
      end
      default: begin
        imm = 32'd0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import rvCtrlPkg::*; (
  input  aluOpT       aluOp,
  input  logic [31:0] a,
  input  logic [31:0] b,
  output logic [31:0] y
);

  logic [4:0] shamt;
  logic       eq;
  logic       lt;
  logic       ltu;
  logic       cmpRaw;
  logic       cmp;

  assign shamt = b[4:0];
  assign eq    = (a == b);
  assign lt    = ($signed(a) < $signed(b));
  assign ltu   = (a < b);

  always_comb begin
    case (aluOp[1:0])
      2'b00:   cmpRaw = eq;
      2'b01:   cmpRaw = lt;
      2'b10:   cmpRaw = ltu;
      default: cmpRaw = 1'b0;
    endcase
  end

  // bne, bge and bgeu flip the base compare
  assign cmp = cmpRaw ^ aluOp[2];

  always_comb begin
    case (aluOp)
      aluAdd:  y = a + b;
      aluSub:  y = a - b;
      aluAnd:  y = a & b;
      aluOr:   y = a | b;
      aluXor:  y = a ^ b;
      aluSll:  y = a << shamt;
      aluSrl:  y = a >> shamt;
      aluSra:  y = $signed(a) >>> shamt;
      // slt, sltu and all branch compares
      default: y = aluOp[3] ? {31'd0, cmp} : 32'd0;
    endcase
  end

endmodule

`default_nettype wire

//--- regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  logic        clk,
  input  logic [4:0]  ra1,
  input  logic [4:0]  ra2,
  output logic [31:0] rd1,
  output logic [31:0] rd2,
  input  logic        we,
  input  logic [4:0]  wa,
  input  logic [31:0] wd
);

  logic [31:0] regs [0:31];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (we && wa != 5'd0) begin
      regs[wa] <= wd;
    end
  end

  assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
  assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

endmodule

`default_nettype wire

//--- dataMem.sv
`timescale 1ns/1ps
`default_nettype none

module dataMem #(
  parameter int dmemWords = 256
) (
  input  logic        clk,
  input  logic        we,
  input  logic [31:0] addr,
  input  logic [31:0] wd,
  output logic [31:0] rd
);

  localparam int addrBits = $clog2(dmemWords);

  logic [31:0]         mem [0:dmemWords-1];
  logic [addrBits-1:0] idx;

  // word index, wraps at a power-of-two depth
  assign idx = addr[addrBits+1:2];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[idx] <= wd;
    end
  end

  assign rd = mem[idx];

endmodule

`default_nettype wire

//--- rvCore.sv
`timescale 1ns/1ps
`default_nettype none

module rvCore import rvIsaPkg::*, rvCtrlPkg::*; #(
  parameter int          dmemWords = 256,
  parameter logic [31:0] resetPc   = 32'h0
) (
  input  logic        clk,
  input  logic        reset,
  output logic [31:0] pc,
  input  logic [31:0] instr,
  output logic        memWrite,
  output logic [31:0] memAddr,
  output logic [31:0] memWdata
);

  rvInstr      instrWord;
  logic [31:0] imm;
  logic [31:0] rd1;
  logic [31:0] rd2;
  logic [31:0] opA;
  logic [31:0] opB;
  logic [31:0] aluY;
  logic [31:0] loadData;
  logic [31:0] wbData;
  logic [31:0] pcPlus4;
  logic [31:0] pcNext;
  pcSelT       pcSel;

  ctrlIf ctrl ();

  assign instrWord = instr;
  assign pcPlus4   = pc + 32'd4;

  instrDecoder uDecoder (
    .instr (instrWord),
    .ctrl  (ctrl.decoder)
  );

  immGen uImmGen (
    .instr   (instrWord),
    .immKind (ctrl.immKind),
    .imm     (imm)
  );

  regFile uRegFile (
    .clk (clk),
    .ra1 (instrWord.r.rs1),
    .ra2 (instrWord.r.rs2),
    .rd1 (rd1),
    .rd2 (rd2),
    .we  (ctrl.regWrite),
    .wa  (instrWord.r.rd),
    .wd  (wbData)
  );

  always_comb begin
    case (ctrl.aSel)
      aRs1:    opA = rd1;
      aPc:     opA = pc;
      default: opA = 32'd0;
    endcase
  end

  assign opB = ctrl.bImm ? imm : rd2;

  alu uAlu (
    .aluOp (ctrl.aluOp),
    .a     (opA),
    .b     (opB),
    .y     (aluY)
  );

  dataMem #(
    .dmemWords (dmemWords)
  ) uDataMem (
    .clk  (clk),
    .we   (ctrl.memWrite),
    .addr (aluY),
    .wd   (rd2),
    .rd   (loadData)
  );

  always_comb begin
    case (ctrl.wbSel)
      wbMem:   wbData = loadData;
      wbLink:  wbData = pcPlus4;
      default: wbData = aluY;
    endcase
  end

  // alu bit 0 carries the branch decision
  always_comb begin
    if (ctrl.isJalr) begin
      pcSel = nextAlu;
    end else if (ctrl.isJal || (ctrl.isBranch && aluY[0])) begin
      pcSel = nextBranch;
    end else begin
      pcSel = nextSeq;
    end
  end

  always_comb begin
    case (pcSel)
      nextBranch: pcNext = pc + imm;
      nextAlu:    pcNext = {aluY[31:1], 1'b0};
      default:    pcNext = pcPlus4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= resetPc;
    end else begin
      pc <= pcNext;
    end
  end

  assign memWrite = ctrl.memWrite;
  assign memAddr  = aluY;
  assign memWdata = rd2;

endmodule

`default_nettype wire

//--- rvCore_chk.sv
`timescale 1ns/1ps
`default_nettype none

module rvCore_chk #(
  parameter logic [31:0] resetPc = 32'h0
) (
  input logic        clk,
  input logic        reset,
  input logic [31:0] pc,
  input logic        memWrite,
  input logic [31:0] memAddr
);

  // fetch addresses stay on word boundaries
  pcAligned: assert property (
    @(posedge clk) disable iff (reset) pc[1:0] == 2'b00
  ) else $error("pc %h is not word aligned", pc);

  pcFromReset: assert property (
    @(posedge clk) reset |=> pc == resetPc
  ) else $error("pc %h is not the reset value after reset", pc);

  // store strobe comes straight from decode
  memWriteKnown: assert property (
    @(posedge clk) !$isunknown(memWrite)
  ) else $error("memWrite is unknown");

  // word stores only
  storeAligned: assert property (
    @(posedge clk) disable iff (reset) memWrite |-> memAddr[1:0] == 2'b00
  ) else $error("store address %h is not word aligned", memAddr);

endmodule

`default_nettype wire

//--- rvCore_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rvCore_tb import rvIsaPkg::*; ();

  localparam int          clkPeriod  = 40;
  localparam int          driveDelay = 1;
  localparam int          cycleLimit = 2000;
  // addi x0, x0, 0
  localparam logic [31:0] nop        = 32'h00000013;
  localparam logic [4:0]  baseReg    = 5'd31;
  localparam logic [31:0] baseAddr   = 32'h00000100;

  logic        clk;
  logic        reset;
  logic [31:0] pc;
  logic [31:0] instr;
  logic        memWrite;
  logic [31:0] memAddr;
  logic [31:0] memWdata;

  int          errors;
  int          checks;
  int          cycles;
  logic [31:0] rngState;
  // pc of the instruction being served, and of the next one
  logic [31:0] curPc;
  logic [31:0] expPc;

  rvCore dut (
    .clk      (clk),
    .reset    (reset),
    .pc       (pc),
    .instr    (instr),
    .memWrite (memWrite),
    .memAddr  (memAddr),
    .memWdata (memWdata)
  );

  bind rvCore rvCore_chk #(
    .resetPc (resetPc)
  ) uChk (
    .clk      (clk),
    .reset    (reset),
    .pc       (pc),
    .memWrite (memWrite),
    .memAddr  (memAddr)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  function logic [31:0] lcgNext();
    rngState = rngState * 32'd1103515245 + 32'd12345;
    return rngState;
  endfunction

  // word-aligned store offset in -64..60
  function logic [11:0] nextOff();
    logic [31:0] r;
    r = lcgNext();
    return {{6{r[6]}}, r[5:2], 2'b00};
  endfunction

  function automatic logic [31:0] encR(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                       logic [4:0] rs1, logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, opReg};
  endfunction

  function automatic logic [31:0] encI(logic [6:0] op, logic [2:0] f3, logic [4:0] rd,
                                       logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encS(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3Word, imm[4:0], opStore};
  endfunction

  function automatic logic [31:0] encB(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                       logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
  endfunction

  function automatic logic [31:0] encU(logic [6:0] op, logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] encJ(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, opJal};
  endfunction

  // expected result of an ALU instruction by the ISA rules
  function automatic logic [31:0] aluModel(logic [2:0] f3, logic alt, logic [31:0] a,
                                           logic [31:0] b);
    case (f3)
      f3AddSub: return alt ? a - b : a + b;
      f3Sll:    return a << b[4:0];
      f3Slt:    return {31'd0, $signed(a) < $signed(b)};
      f3Sltu:   return {31'd0, a < b};
      f3Xor:    return a ^ b;
      f3SrlSra: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      f3Or:     return a | b;
      default:  return a & b;
    endcase
  endfunction

  function automatic logic branchTaken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      f3Beq:   return a == b;
      f3Bne:   return a != b;
      f3Blt:   return $signed(a) < $signed(b);
      f3Bge:   return $signed(a) >= $signed(b);
      f3Bltu:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic checkEq(string name, logic [31:0] got, logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Fail at %0t: %s is %h, expected %h", $time, name, got, want);
    end
  endtask

  task automatic applyReset();
    reset = 1'b1;
    instr = nop;
    repeat (4) @(posedge clk);
    #driveDelay;
    reset = 1'b0;
    @(negedge clk);
    checkEq("pc after reset", pc, 32'h0);
    // the nop at pc 0 runs in this cycle
    expPc = 32'd4;
  endtask

  // serve one instruction, outputs are checked mid-cycle
  task automatic step(logic [31:0] word);
    @(posedge clk);
    #driveDelay;
    instr = word;
    curPc = expPc;
    expPc = expPc + 32'd4;
    @(negedge clk);
    checkEq("pc", pc, curPc);
    checkEq("memWrite", {31'd0, memWrite}, {31'd0, word[6:0] == opStore});
  endtask

  task automatic storeCheck(string name, logic [4:0] src, logic [11:0] off,
                            logic [31:0] want);
    step(encS(src, baseReg, off));
    checkEq("memAddr", memAddr, baseAddr + {{20{off[11]}}, off});
    checkEq(name, memWdata, want);
  endtask

  // lui plus addi, upper part rounded for the sign of the low 12 bits
  task automatic loadReg(logic [4:0] rd, logic [31:0] value);
    logic [19:0] hi;
    hi = value[31:12] + {19'd0, value[11]};
    step(encU(opLui, rd, hi));
    step(encI(opImm, f3AddSub, rd, rd, value[11:0]));
  endtask

  task automatic testAlu();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [11:0] imm;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic        alt;
    for (int round = 0; round < 4; round++) begin
      a = lcgNext();
      b = lcgNext();
      loadReg(5'd1, a);
      loadReg(5'd2, b);
      for (int f = 0; f < 16; f++) begin
        f3  = f[2:0];
        alt = f[3];
        f7  = alt ? f7Alt : f7Base;
        if (alt && f3 != f3AddSub && f3 != f3SrlSra) begin
          continue;
        end
        step(encR(f7, f3, 5'd3, 5'd1, 5'd2));
        storeCheck("memWdata reg op", 5'd3, nextOff(), aluModel(f3, alt, a, b));
        // no subi
        if (alt && f3 == f3AddSub) begin
          continue;
        end
        r   = lcgNext();
        imm = (f3 == f3Sll || f3 == f3SrlSra) ? {f7, r[4:0]} : r[11:0];
        step(encI(opImm, f3, 5'd4, 5'd1, imm));
        storeCheck("memWdata imm op", 5'd4, nextOff(),
                   aluModel(f3, alt, a, {{20{imm[11]}}, imm}));
      end
    end
  endtask

  task automatic testMemory();
    logic [31:0] vals [4];
    logic [11:0] offs [4];
    for (int k = 0; k < 4; k++) begin
      vals[k] = lcgNext();
      offs[k] = 12'h040 + 12'(k * 8);
      loadReg(5'd5, vals[k]);
      storeCheck("memWdata store", 5'd5, offs[k], vals[k]);
    end
    for (int k = 0; k < 4; k++) begin
      step(encI(opLoad, f3Word, 5'(10 + k), baseReg, offs[k]));
      checkEq("memAddr load", memAddr, baseAddr + {20'd0, offs[k]});
    end
    // copy each reloaded word somewhere else
    for (int k = 0; k < 4; k++) begin
      storeCheck("memWdata reload", 5'(10 + k), offs[k] + 12'h080, vals[k]);
    end
  endtask

  task automatic testBranches();
    logic [2:0]  kinds [6];
    logic [31:0] pos;
    logic [31:0] neg;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [12:0] off;
    kinds = '{f3Beq, f3Bne, f3Blt, f3Bge, f3Bltu, f3Bgeu};
    for (int k = 0; k < 6; k++) begin
      // equal, pos vs neg, neg vs pos covers taken and not taken
      for (int p = 0; p < 3; p++) begin
        pos = lcgNext() & 32'h7fffffff;
        neg = lcgNext() | 32'h80000000;
        a   = (p == 2) ? neg : pos;
        b   = (p == 0) ? pos : ((p == 1) ? neg : pos);
        loadReg(5'd6, a);
        loadReg(5'd7, b);
        r   = lcgNext();
        off = {r[12:2], 2'b00};
        step(encB(kinds[k], 5'd6, 5'd7, off));
        if (branchTaken(kinds[k], a, b)) begin
          expPc = curPc + {{19{off[12]}}, off};
        end
      end
    end
  endtask

  task automatic testJumps();
    logic [31:0] r;
    logic [31:0] link;
    logic [31:0] base;
    logic [31:0] sum;
    logic [20:0] jOff;
    logic [11:0] imm;
    r    = lcgNext();
    jOff = {r[20:2], 2'b00};
    step(encJ(5'd8, jOff));
    link  = curPc + 32'd4;
    expPc = curPc + {{11{jOff[20]}}, jOff};
    storeCheck("memWdata jal link", 5'd8, nextOff(), link);
    // odd target, bit 0 must be dropped
    r    = lcgNext();
    base = {r[31:2], 2'b00};
    r    = lcgNext();
    imm  = {r[11:2], 2'b01};
    loadReg(5'd9, base);
    step(encI(opJalr, f3Jalr, 5'd8, 5'd9, imm));
    link  = curPc + 32'd4;
    sum   = base + {{20{imm[11]}}, imm};
    expPc = {sum[31:1], 1'b0};
    storeCheck("memWdata jalr link", 5'd8, nextOff(), link);
    r = lcgNext();
    step(encU(opAuipc, 5'd12, r[19:0]));
    storeCheck("memWdata auipc", 5'd12, nextOff(), curPc + {r[19:0], 12'd0});
    r = lcgNext();
    step(encU(opLui, 5'd13, r[31:12]));
    storeCheck("memWdata lui", 5'd13, nextOff(), {r[31:12], 12'd0});
  endtask

  task automatic testZero();
    step(encI(opImm, f3AddSub, 5'd0, 5'd0, 12'h5a5));
    step(encU(opLui, 5'd0, 20'habcde));
    storeCheck("memWdata x0", 5'd0, nextOff(), 32'd0);
  endtask

  initial begin
    instr    = nop;
    reset    = 1'b1;
    errors   = 0;
    checks   = 0;
    rngState = 32'd49048;
    curPc    = 32'd0;
    expPc    = 32'd0;
    applyReset();
    loadReg(baseReg, baseAddr);
    testAlu();
    testMemory();
    testBranches();
    testJumps();
    testZero();
    @(posedge clk);
    #driveDelay;
    instr = nop;
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // run limit, well above the cycles the tests need
  initial begin
    cycles = 0;
    while (cycles < cycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, tests did not finish", cycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
rvIsaPkg.sv
rvCtrlPkg.sv
ctrlIf.sv
instrDecoder.sv
immGen.sv
alu.sv
regFile.sv
dataMem.sv
rvCore.sv
rvCore_chk.sv
rvCore_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= rvCore_tb
FILELIST  ?= build.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | awk '{ print } /^TEST PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
